// ==== hw/ecc_pkg.sv ====
package ecc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // code geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int DATA_W   = 40;
    localparam int PARITY_W = 7;

    typedef logic [DATA_W-1:0]   data_t;     // payload word.
    typedef logic [PARITY_W-1:0] parity_t;   // check bits.
    typedef logic [PARITY_W-1:0] syndrome_t; // stored ^ recomputed.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // check-bit encoder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // column of data bit i in H matches the syndrome table in ecc_40_cal.
    function automatic parity_t ecc_encode(input data_t d);
        parity_t p;
        p[0] = d[0]  ^ d[1]  ^ d[3]  ^ d[4]  ^ d[6]  ^ d[8]  ^ d[10] ^ d[11] ^
               d[13] ^ d[15] ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^
               d[28] ^ d[30] ^ d[32] ^ d[34] ^ d[36] ^ d[38];
        p[1] = d[0]  ^ d[2]  ^ d[3]  ^ d[5]  ^ d[6]  ^ d[9]  ^ d[10] ^ d[12] ^
               d[13] ^ d[16] ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^
               d[28] ^ d[31] ^ d[32] ^ d[35] ^ d[36] ^ d[39];
        p[2] = d[1]  ^ d[2]  ^ d[3]  ^ d[7]  ^ d[8]  ^ d[9]  ^ d[10] ^ d[14] ^
               d[15] ^ d[16] ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^
               d[30] ^ d[31] ^ d[32] ^ d[37] ^ d[38] ^ d[39];
        p[3] = d[4]  ^ d[5]  ^ d[6]  ^ d[7]  ^ d[8]  ^ d[9]  ^ d[10] ^ d[18] ^
               d[19] ^ d[20] ^ d[21] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[33] ^
               d[34] ^ d[35] ^ d[36] ^ d[37] ^ d[38] ^ d[39];
        p[4] = ^d[25:11]; // contiguous group.
        p[5] = ^d[39:26];
        p[6] = d[0]  ^ d[1]  ^ d[2]  ^ d[4]  ^ d[5]  ^ d[7]  ^ d[10] ^ d[11] ^
               d[12] ^ d[14] ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^
               d[27] ^ d[29] ^ d[32] ^ d[33] ^ d[36] ^ d[38] ^ d[39];
        return p;
    endfunction

endpackage

// ==== hw/mem_pkg.sv ====
package mem_pkg;

    import ecc_pkg::*;

    localparam int DEF_ADDR_W  = 6; // default array depth is 64.
    localparam int DEF_COUNT_W = 8;

    typedef logic [DEF_ADDR_W-1:0]  addr_t;
    typedef logic [DEF_COUNT_W-1:0] count_t;

    typedef struct packed {
        parity_t parity;
        data_t   data;
    } mem_word_t; // stored form, also the injection mask.

    typedef struct packed {
        addr_t addr;
        logic  bypass;
    } rd_tag_t;

    typedef struct packed {
        data_t   data;
        parity_t parity;   // recomputed check bits.
        logic    sbit_err;
        logic    dbit_err;
    } rd_resp_t;

    typedef struct packed {
        count_t sbit_cnt;
        count_t dbit_cnt;
        addr_t  last_addr;
    } err_log_t;

endpackage

// ==== hw/ecc_40_cal.sv ====
module ecc_40_cal (
    input  mem_pkg::mem_word_t stored,
    input  logic               bypass,
    output mem_pkg::rd_resp_t  resp
);

    import ecc_pkg::*;

    parity_t   recomputed;
    syndrome_t syndrome;
    data_t     mask;
    logic      sbit_hit;
    logic      dbit_hit;

    assign recomputed = ecc_encode(stored.data);
    assign syndrome   = stored.parity ^ recomputed;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // syndrome decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        mask     = '0;
        sbit_hit = 1'b1;
        dbit_hit = 1'b0;
        case (syndrome)
            7'b0000000: sbit_hit = 1'b0; // clean.
            7'b1000011: mask[0]  = 1'b1;
            7'b1000101: mask[1]  = 1'b1;
            7'b1000110: mask[2]  = 1'b1;
            7'b0000111: mask[3]  = 1'b1;
            7'b1001001: mask[4]  = 1'b1;
            7'b1001010: mask[5]  = 1'b1;
            7'b0001011: mask[6]  = 1'b1;
            7'b1001100: mask[7]  = 1'b1;
            7'b0001101: mask[8]  = 1'b1;
            7'b0001110: mask[9]  = 1'b1;
            7'b1001111: mask[10] = 1'b1;
            7'b1010001: mask[11] = 1'b1;
            7'b1010010: mask[12] = 1'b1;
            7'b0010011: mask[13] = 1'b1;
            7'b1010100: mask[14] = 1'b1;
            7'b0010101: mask[15] = 1'b1;
            7'b0010110: mask[16] = 1'b1;
            7'b1010111: mask[17] = 1'b1;
            7'b1011000: mask[18] = 1'b1;
            7'b0011001: mask[19] = 1'b1;
            7'b0011010: mask[20] = 1'b1;
            7'b1011011: mask[21] = 1'b1;
            7'b0011100: mask[22] = 1'b1;
            7'b1011101: mask[23] = 1'b1;
            7'b1011110: mask[24] = 1'b1;
            7'b0011111: mask[25] = 1'b1;
            7'b1100001: mask[26] = 1'b1;
            7'b1100010: mask[27] = 1'b1;
            7'b0100011: mask[28] = 1'b1;
            7'b1100100: mask[29] = 1'b1;
            7'b0100101: mask[30] = 1'b1;
            7'b0100110: mask[31] = 1'b1;
            7'b1100111: mask[32] = 1'b1;
            7'b1101000: mask[33] = 1'b1;
            7'b0101001: mask[34] = 1'b1;
            7'b0101010: mask[35] = 1'b1;
            7'b1101011: mask[36] = 1'b1;
            7'b0101100: mask[37] = 1'b1;
            7'b1101101: mask[38] = 1'b1;
            7'b1101110: mask[39] = 1'b1;
            // a flipped check bit leaves the data alone.
            7'b1000000, 7'b0100000, 7'b0010000, 7'b0001000,
            7'b0000100, 7'b0000010, 7'b0000001: mask = '0;
            default: begin // not correctable.
                sbit_hit = 1'b0;
                dbit_hit = 1'b1;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign resp.data     = bypass ? stored.data : stored.data ^ mask;
    assign resp.parity   = recomputed;
    assign resp.sbit_err = sbit_hit & ~bypass;
    assign resp.dbit_err = dbit_hit & ~bypass;

endmodule

// ==== hw/ecc_mem_array.sv ====
module ecc_mem_array #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  mem_pkg::mem_word_t    wr_word,
    input  logic                  rd_en,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    input  logic                  bypass,
    output logic                  rd_valid,
    output mem_pkg::mem_word_t    rd_word,
    output mem_pkg::rd_tag_t      rd_tag
);

    import mem_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    mem_word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // same-address write lands after this read, so old word returns.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word       <= mem[rd_addr];
            rd_tag.addr   <= addr_t'(rd_addr);
            rd_tag.bypass <= bypass;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en; // one cycle latency.
        end
    end

endmodule

// ==== hw/ecc_err_log.sv ====
module ecc_err_log #(
    parameter int ADDR_WIDTH  = 6,
    parameter int COUNT_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clr,
    input  logic                  valid,
    input  logic                  sbit_err,
    input  logic                  dbit_err,
    input  logic [ADDR_WIDTH-1:0] addr,
    output mem_pkg::err_log_t     log
);

    import mem_pkg::*;

    localparam logic [COUNT_WIDTH-1:0] CNT_MAX = '1;

    logic [COUNT_WIDTH-1:0] s_cnt;
    logic [COUNT_WIDTH-1:0] d_cnt;
    logic [ADDR_WIDTH-1:0]  last_addr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_cnt       <= '0;
            d_cnt       <= '0;
            last_addr_q <= '0;
        end else if (clr) begin
            s_cnt       <= '0; // clear wins over a pending read.
            d_cnt       <= '0;
            last_addr_q <= '0;
        end else if (valid) begin
            if (sbit_err && s_cnt != CNT_MAX) begin
                s_cnt <= s_cnt + 1'b1;
            end
            if (dbit_err && d_cnt != CNT_MAX) begin
                d_cnt <= d_cnt + 1'b1;
            end
            if (sbit_err || dbit_err) begin
                last_addr_q <= addr;
            end
        end
    end

    assign log.sbit_cnt  = count_t'(s_cnt);
    assign log.dbit_cnt  = count_t'(d_cnt);
    assign log.last_addr = addr_t'(last_addr_q);

endmodule

// ==== hw/ecc_mem_top.sv ====
module ecc_mem_top #(
    parameter int ADDR_WIDTH  = 6,
    parameter int COUNT_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // write port
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  ecc_pkg::data_t        wr_data,
    input  mem_pkg::mem_word_t    wr_inj,
    // read port
    input  logic                  rd_en,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    input  logic                  bypass,
    input  logic                  log_clr,
    output logic                  rd_valid,
    output mem_pkg::rd_resp_t     rd_resp,
    output mem_pkg::err_log_t     err_log
);

    import ecc_pkg::*;
    import mem_pkg::*;

    mem_word_t             enc_word;
    mem_word_t             wr_word;
    mem_word_t             rd_word;
    rd_tag_t               rd_tag;
    logic [ADDR_WIDTH-1:0] rd_tag_addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign enc_word.parity = ecc_encode(wr_data);
    assign enc_word.data   = wr_data;
    assign wr_word         = enc_word ^ wr_inj; // diagnostic flips.

    ecc_mem_array #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_word  (wr_word),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .bypass   (bypass),
        .rd_valid (rd_valid),
        .rd_word  (rd_word),
        .rd_tag   (rd_tag)
    );

    ecc_40_cal u_cal (
        .stored (rd_word),
        .bypass (rd_tag.bypass),
        .resp   (rd_resp)
    );

    assign rd_tag_addr = ADDR_WIDTH'(rd_tag.addr);

    ecc_err_log #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_log (
        .clk      (clk),
        .rst_n    (rst_n),
        .clr      (log_clr),
        .valid    (rd_valid),
        .sbit_err (rd_resp.sbit_err),
        .dbit_err (rd_resp.dbit_err),
        .addr     (rd_tag_addr),
        .log      (err_log)
    );

endmodule

// ==== tests/ecc_mem_sva.sv ====
module ecc_mem_sva (
    input logic              clk,
    input logic              rst_n,
    input logic              rd_en,
    input logic              rd_valid,
    input logic              tag_bypass,
    input mem_pkg::rd_resp_t rd_resp
);

    timeunit 1ns;
    timeprecision 100ps;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_valid_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |=> rd_valid)
        else $error("rd_valid missing one cycle after rd_en");

    a_no_spurious_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !rd_en |=> !rd_valid)
        else $error("rd_valid high without a read one cycle earlier");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // flag rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> !(rd_resp.sbit_err && rd_resp.dbit_err))
        else $error("single and double error flags high together");

    a_bypass_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid && tag_bypass |-> !rd_resp.sbit_err && !rd_resp.dbit_err)
        else $error("error flag raised on a bypass read");

endmodule

bind ecc_mem_top ecc_mem_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_en      (rd_en),
    .rd_valid   (rd_valid),
    .tag_bypass (rd_tag.bypass), // bypass bit travelling with the read.
    .rd_resp    (rd_resp)
);

// ==== tests/ecc_mem_tb.sv ====
module ecc_mem_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import ecc_pkg::*;
    import mem_pkg::*;

    localparam int ADDR_WIDTH  = 6;
    localparam int COUNT_WIDTH = 8;
    localparam int HALF_PERIOD = 20;
    localparam int DRIVE_DLY   = 2;
    localparam int TIMEOUT     = 20;
    localparam int SAT_READS   = 270; // enough to pass 255.

    logic                  clk;
    logic                  rst_n;
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    data_t                 wr_data;
    mem_word_t             wr_inj;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic                  bypass;
    logic                  log_clr;
    logic                  rd_valid;
    rd_resp_t              rd_resp;
    err_log_t              err_log;

    integer   seed = 77121;
    err_log_t exp_log;
    int       n_data_err;
    int       n_parity_err;
    int       n_flag_err;
    int       n_log_err;
    int       n_other_err;

    ecc_mem_top #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .COUNT_WIDTH (COUNT_WIDTH)
    ) dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_inj   (wr_inj),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .bypass   (bypass),
        .log_clr  (log_clr),
        .rd_valid (rd_valid),
        .rd_resp  (rd_resp),
        .err_log  (err_log)
    );

    always #HALF_PERIOD clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            n_data_err++;
        end
    endtask

    task automatic check_parity(input string name, input parity_t got, input parity_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            n_parity_err++;
        end
    endtask

    task automatic check_flags(input string name, input logic [1:0] got,
                               input logic [1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            n_flag_err++;
        end
    endtask

    task automatic check_log(input string name, input err_log_t got, input err_log_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d/%0d/%0d expected %0d/%0d/%0d",
                     $time, name, got.sbit_cnt, got.dbit_cnt, got.last_addr,
                     exp.sbit_cnt, exp.dbit_cnt, exp.last_addr);
            n_log_err++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drivers and model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic data_t rand_data();
        return data_t'({$random(seed), $random(seed)});
    endfunction

    // hamming positions without powers of two, top bit makes each column odd.
    function automatic parity_t ref_check_bits(input data_t d);
        parity_t    p;
        logic [5:0] pos;
        p   = '0;
        pos = 6'd2;
        for (int i = 0; i < DATA_W; i++) begin
            pos++;
            if ((pos & (pos - 1'b1)) == '0) pos++;
            if (d[i]) p ^= {~^pos, pos};
        end
        return p;
    endfunction

    task automatic log_expect(input logic sbit, input logic dbit,
                              input logic [ADDR_WIDTH-1:0] addr);
        if (sbit && exp_log.sbit_cnt != '1) exp_log.sbit_cnt = exp_log.sbit_cnt + 1'b1;
        if (dbit && exp_log.dbit_cnt != '1) exp_log.dbit_cnt = exp_log.dbit_cnt + 1'b1;
        exp_log.last_addr = addr;
    endtask

    task automatic write_word(input logic [ADDR_WIDTH-1:0] addr, input data_t data,
                              input mem_word_t inj);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        wr_inj  = inj;
        @(posedge clk);
        #DRIVE_DLY;
        wr_en  = 1'b0;
        wr_inj = '0;
    endtask

    task automatic check_read(input logic [ADDR_WIDTH-1:0] addr, input logic byp,
                              input data_t raw, input data_t exp_data,
                              input logic [1:0] exp_flags);
        int waited;
        waited  = 0;
        rd_en   = 1'b1;
        rd_addr = addr;
        bypass  = byp;
        @(posedge clk);
        #DRIVE_DLY;
        rd_en  = 1'b0;
        bypass = 1'b0;
        while (!rd_valid && waited < TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end
        if (!rd_valid) begin
            $display("read of address %0d got no rd_valid within %0d cycles", addr, TIMEOUT);
            n_other_err++;
        end
        check_data("rd_resp.data", rd_resp.data, exp_data);
        check_parity("rd_resp.parity", rd_resp.parity, ref_check_bits(raw));
        check_flags("rd_resp.sbit_err/dbit_err", {rd_resp.sbit_err, rd_resp.dbit_err},
                    exp_flags);
        if (exp_flags != 2'b00) log_expect(exp_flags[1], exp_flags[0], addr);
        @(posedge clk); // log catches up one edge later.
        #DRIVE_DLY;
        check_log("err_log", err_log, exp_log);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_clean;
        logic [ADDR_WIDTH-1:0] addr;
        data_t                 data;
        repeat (8) begin
            addr = ADDR_WIDTH'($random(seed));
            data = rand_data();
            write_word(addr, data, '0);
            check_read(addr, 1'b0, data, data, 2'b00);
        end
    endtask

    task automatic test_single_data;
        data_t     data;
        mem_word_t inj;
        for (int i = 0; i < DATA_W; i++) begin
            data        = rand_data();
            inj         = '0;
            inj.data[i] = 1'b1;
            write_word(ADDR_WIDTH'(i), data, inj);
            check_read(ADDR_WIDTH'(i), 1'b0, data ^ inj.data, data, 2'b10);
        end
    endtask

    task automatic test_single_parity;
        data_t     data;
        mem_word_t inj;
        for (int i = 0; i < PARITY_W; i++) begin
            data          = rand_data();
            inj           = '0;
            inj.parity[i] = 1'b1;
            write_word(ADDR_WIDTH'(48 + i), data, inj);
            check_read(ADDR_WIDTH'(48 + i), 1'b0, data, data, 2'b10);
        end
    endtask

    task automatic test_double;
        data_t     data;
        mem_word_t inj;
        int        i;
        int        j;
        for (int n = 0; n < 10; n++) begin
            i           = int'($unsigned($random(seed)) % DATA_W);
            j           = (i + 1 + int'($unsigned($random(seed)) % (DATA_W - 1))) % DATA_W;
            data        = rand_data();
            inj         = '0;
            inj.data[i] = 1'b1;
            inj.data[j] = 1'b1;
            write_word(ADDR_WIDTH'(n + 1), data, inj);
            check_read(ADDR_WIDTH'(n + 1), 1'b0, data ^ inj.data, data ^ inj.data, 2'b01);
        end
    endtask

    task automatic test_bypass;
        data_t     data;
        mem_word_t inj;
        data         = rand_data();
        inj          = '0;
        inj.data[7]  = 1'b1;
        inj.data[30] = 1'b1;
        write_word(ADDR_WIDTH'(60), data, inj);
        // raw, log untouched.
        check_read(ADDR_WIDTH'(60), 1'b1, data ^ inj.data, data ^ inj.data, 2'b00);
        inj          = '0;
        inj.data[12] = 1'b1;
        write_word(ADDR_WIDTH'(61), data, inj);
        check_read(ADDR_WIDTH'(61), 1'b1, data ^ inj.data, data ^ inj.data, 2'b00);
    endtask

    task automatic test_log;
        data_t     data;
        mem_word_t inj;
        data        = rand_data();
        inj         = '0;
        inj.data[5] = 1'b1;
        write_word(ADDR_WIDTH'(17), data, inj);
        rd_en   = 1'b1;
        rd_addr = ADDR_WIDTH'(17);
        for (int k = 0; k < SAT_READS; k++) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (k == SAT_READS - 1) rd_en = 1'b0;
            if (!rd_valid) begin
                $display("rd_valid low during back-to-back read %0d", k);
                n_other_err++;
            end
            check_data("rd_resp.data", rd_resp.data, data);
            check_parity("rd_resp.parity", rd_resp.parity, ref_check_bits(data ^ inj.data));
            check_flags("rd_resp.sbit_err/dbit_err", {rd_resp.sbit_err, rd_resp.dbit_err},
                        2'b10);
            log_expect(1'b1, 1'b0, ADDR_WIDTH'(17));
        end
        @(posedge clk);
        #DRIVE_DLY;
        check_log("err_log saturated", err_log, exp_log);
        write_word(ADDR_WIDTH'(42), data, inj);
        check_read(ADDR_WIDTH'(42), 1'b0, data ^ inj.data, data, 2'b10);
        log_clr = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        log_clr = 1'b0;
        exp_log = '0;
        check_log("err_log after clear", err_log, exp_log);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        wr_inj       = '0;
        rd_en        = 1'b0;
        rd_addr      = '0;
        bypass       = 1'b0;
        log_clr      = 1'b0;
        exp_log      = '0;
        n_data_err   = 0;
        n_parity_err = 0;
        n_flag_err   = 0;
        n_log_err    = 0;
        n_other_err  = 0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        if (rd_valid !== 1'b0) begin
            $display("rd_valid is not low after reset");
            n_other_err++;
        end
        check_log("err_log after reset", err_log, exp_log);
        test_clean();
        test_single_data();
        test_single_parity();
        test_double();
        test_bypass();
        test_log();
        $display("errors: data %0d, parity %0d, flags %0d, log %0d, other %0d",
                 n_data_err, n_parity_err, n_flag_err, n_log_err, n_other_err);
        if (n_data_err + n_parity_err + n_flag_err + n_log_err + n_other_err == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hw/ecc_pkg.sv
hw/mem_pkg.sv
hw/ecc_40_cal.sv
hw/ecc_mem_array.sv
hw/ecc_err_log.sv
hw/ecc_mem_top.sv
tests/ecc_mem_sva.sv
tests/ecc_mem_tb.sv

// ==== Makefile ====
SIM       := verilator
TOP       := ecc_mem_tb
FILELIST  := list.f
FLAGS     := --binary --timing --assert
LINTFLAGS := --lint-only --timing -Wall
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TEST FAIL

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(SIM) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
